// File: all.f
src/i2s_rx_pkg.sv
src/i2s_pin_sync.sv
src/i2s_deserializer.sv
src/i2s_bist_gen.sv
src/sample_fifo.sv
src/i2s_rx_lane.sv
src/i2s_rx_arbiter.sv
src/i2s_rx_top.sv
testbench/tb_clock_gen.sv
testbench/i2s_rx_tb.sv

// File: src/i2s_bist_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Self-test source. One frame per 32 bit-clock rises, carrying a
// counter that steps by bist_inc and wraps to bist_start past the limit.

module i2s_bist_gen (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 sck_rise,
    input  wire                 run,
    input  wire  [31:0]         bist_start,
    input  wire  [31:0]         bist_limit,
    input  wire  [7:0]          bist_inc,
    output i2s_rx_pkg::frame_t  frame,
    output logic                frame_valid
);

    logic [4:0]  bit_cnt;                           // sck rises within a frame
    logic [31:0] count_q;                           // Value of next frame
    logic [32:0] count_sum;                         // Extra bit catches carry
    logic        emit;

    assign emit      = run & sck_rise & (bit_cnt == 5'd31);
    assign count_sum = {1'b0, count_q} + {25'd0, bist_inc};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt     <= '0;
            count_q     <= '0;
            frame_valid <= 1'b0;
        end
        else if (!run)
        begin
            bit_cnt     <= '0;
            count_q     <= bist_start;              // Preload while idle
            frame_valid <= 1'b0;
        end
        else
        begin
            frame_valid <= emit;
            if (sck_rise)
                bit_cnt <= bit_cnt + 5'd1;          // Wraps after 32
            if (emit)
            begin
                if (count_sum > {1'b0, bist_limit})
                    count_q <= bist_start;
                else
                    count_q <= count_sum[31:0];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (emit)
            frame <= i2s_rx_pkg::frame_t'(count_q);
    end

endmodule

`default_nettype wire

// File: src/i2s_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

// Standard I2S receive. Data is shifted MSB first on each bit-clock
// rise. A change of ws marks the bit just taken as the LSB of the
// word for the channel that ws selected before the change.

module i2s_deserializer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 sck_rise,
    input  wire                 ws,
    input  wire                 sd,
    input  wire                 enable,
    output i2s_rx_pkg::frame_t  frame,
    output logic                frame_valid
);

    logic [i2s_rx_pkg::SAMPLE_W-1:0] shift_q;       // Serial shift register
    logic [i2s_rx_pkg::SAMPLE_W-1:0] left_q;        // Finished left word
    logic [i2s_rx_pkg::SAMPLE_W-1:0] word;          // Word including current bit
    logic                            ws_prev;       // ws at previous sck rise
    logic                            left_ok;       // Left word waits for its pair
    logic                            word_end;

    assign word     = {shift_q[i2s_rx_pkg::SAMPLE_W-2:0], sd};
    assign word_end = sck_rise & (ws != ws_prev);

    ////////////////////////////////////////
    // Shift and channel tracking
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_q <= '0;
            ws_prev <= 1'b0;
            left_ok <= 1'b0;
        end
        else if (sck_rise)
        begin
            shift_q <= word;
            ws_prev <= ws;
            if (word_end && !ws_prev)
                left_ok <= 1'b1;                    // Left word complete
            else if (word_end)
                left_ok <= 1'b0;                    // Right word consumes the pair
        end
    end

    always_ff @(posedge clk)
    begin
        if (word_end && !ws_prev)
            left_q <= word;
    end

    ////////////////////////////////////////
    // Frame output
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            frame_valid <= 1'b0;
        else
            frame_valid <= word_end & ws_prev & left_ok & enable;
    end

    always_ff @(posedge clk)
    begin
        if (word_end && ws_prev)
        begin
            frame.left  <= left_q;
            frame.right <= word;
        end
    end

endmodule

`default_nettype wire

// File: src/i2s_pin_sync.sv
`timescale 1ns/1ps
`default_nettype none

// Brings the three asynchronous I2S pins into the clk domain.
// Each pin passes two flops; sck has a third flop for edge detection.

module i2s_pin_sync (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  sck_pin,
    input  wire  ws_pin,
    input  wire  sd_pin,
    output logic sck_rise,
    output logic ws,
    output logic sd
);

    logic [2:0] sck_q;                              // Sync stages plus edge flop
    logic [1:0] ws_q;
    logic [1:0] sd_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_q <= '0;
            ws_q  <= '0;
            sd_q  <= '0;
        end
        else
        begin
            sck_q <= {sck_q[1:0], sck_pin};         // Shift toward MSB
            ws_q  <= {ws_q[0], ws_pin};
            sd_q  <= {sd_q[0], sd_pin};
        end
    end

    // Synchronized sck high, delayed copy still low
    assign sck_rise = sck_q[1] & ~sck_q[2];

    assign ws = ws_q[1];
    assign sd = sd_q[1];

endmodule

`default_nettype wire

// File: src/i2s_rx_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_rx_arbiter (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  i2s_rx_pkg::frame_t [i2s_rx_pkg::NUM_LANES-1:0] in_frame,
    input  wire  [i2s_rx_pkg::NUM_LANES-1:0]             in_valid,
    output logic [i2s_rx_pkg::NUM_LANES-1:0]             in_ready,
    output i2s_rx_pkg::rx_word_t                         out_word,
    output logic                                         out_valid,
    input  wire                                          out_ready
);

    logic [i2s_rx_pkg::LANE_W-1:0] ptr;             // First lane to look at
    logic [i2s_rx_pkg::LANE_W-1:0] gnt_idx;
    logic                          gnt_found;
    logic                          load;            // Output register free

    assign load = ~out_valid | out_ready;

    // First valid lane at or after the pointer
    always_comb
    begin
        int idx;
        gnt_found = 1'b0;
        gnt_idx   = '0;
        for (int i = 0; i < i2s_rx_pkg::NUM_LANES; i++)
        begin
            idx = int'(ptr) + i;
            if (idx >= i2s_rx_pkg::NUM_LANES)
                idx = idx - i2s_rx_pkg::NUM_LANES;  // Wrap around
            if (!gnt_found && in_valid[idx])
            begin
                gnt_found = 1'b1;
                gnt_idx   = i2s_rx_pkg::LANE_W'(idx);
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < i2s_rx_pkg::NUM_LANES; i++)
            in_ready[i] = load & gnt_found & (int'(gnt_idx) == i);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            ptr       <= '0;
        end
        else if (load)
        begin
            out_valid <= gnt_found;
            if (gnt_found)
                ptr <= (int'(gnt_idx) == i2s_rx_pkg::NUM_LANES - 1) ? '0 : gnt_idx + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load && gnt_found)
        begin
            out_word.lane  <= gnt_idx;              // Tag with source lane
            out_word.frame <= in_frame[gnt_idx];
        end
    end

endmodule

`default_nettype wire

// File: src/i2s_rx_lane.sv
`timescale 1ns/1ps
`default_nettype none

// One receive lane, from pins to a buffered frame stream

module i2s_rx_lane (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   sck_pin,
    input  wire                   ws_pin,
    input  wire                   sd_pin,
    input  i2s_rx_pkg::i2s_cfg_t  cfg,
    input  wire                   overrun_clr,
    output i2s_rx_pkg::frame_t    out_frame,
    output logic                  out_valid,
    input  wire                   out_ready,
    output logic                  overrun
);

    logic               sck_rise;
    logic               ws_s;
    logic               sd_s;
    i2s_rx_pkg::frame_t des_frame;
    logic               des_valid;
    i2s_rx_pkg::frame_t bist_frame;
    logic               bist_valid;
    i2s_rx_pkg::frame_t src_frame;                  // Selected source
    logic               src_valid;
    logic               fifo_in_ready;

    i2s_pin_sync u_sync (
        .clk         (clk),
        .rst_n       (rst_n),
        .sck_pin     (sck_pin),
        .ws_pin      (ws_pin),
        .sd_pin      (sd_pin),
        .sck_rise    (sck_rise),
        .ws          (ws_s),
        .sd          (sd_s)
    );

    i2s_deserializer u_des (
        .clk         (clk),
        .rst_n       (rst_n),
        .sck_rise    (sck_rise),
        .ws          (ws_s),
        .sd          (sd_s),
        .enable      (cfg.enable & ~cfg.bist_sel),
        .frame       (des_frame),
        .frame_valid (des_valid)
    );

    i2s_bist_gen u_bist (
        .clk         (clk),
        .rst_n       (rst_n),
        .sck_rise    (sck_rise),
        .run         (cfg.enable & cfg.bist_sel),
        .bist_start  (cfg.bist_start),
        .bist_limit  (cfg.bist_limit),
        .bist_inc    (cfg.bist_inc),
        .frame       (bist_frame),
        .frame_valid (bist_valid)
    );

    // Source select
    assign src_frame = cfg.bist_sel ? bist_frame : des_frame;
    assign src_valid = cfg.bist_sel ? bist_valid : des_valid;

    sample_fifo u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_frame    (src_frame),
        .in_valid    (src_valid),
        .in_ready    (fifo_in_ready),
        .out_frame   (out_frame),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    // Sticky overrun, a new drop beats a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            overrun <= 1'b0;
        else if (src_valid && !fifo_in_ready)
            overrun <= 1'b1;
        else if (overrun_clr)
            overrun <= 1'b0;
    end

endmodule

`default_nettype wire

// File: src/i2s_rx_pkg.sv
`default_nettype none

package i2s_rx_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int NUM_LANES  = 2;                  // I2S input lanes
    localparam int SAMPLE_W   = 16;                 // One channel sample
    localparam int FRAME_W    = 2 * SAMPLE_W;       // Left plus right
    localparam int FIFO_DEPTH = 8;                  // Frames per lane FIFO
    localparam int FIFO_AW    = 3;                  // log2 of FIFO_DEPTH
    localparam int LANE_W     = 1;                  // Lane index width

    ////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////

    typedef struct packed {
        logic [SAMPLE_W-1:0] left;                  // Upper half
        logic [SAMPLE_W-1:0] right;                 // Lower half
    } frame_t;

    typedef struct packed {
        logic        enable;                        // Lane on
        logic        bist_sel;                      // 1 selects self-test source
        logic [31:0] bist_start;                    // Counter start value
        logic [31:0] bist_limit;                    // Counter upper limit
        logic [7:0]  bist_inc;                      // Counter step
    } i2s_cfg_t;

    typedef struct packed {
        logic [LANE_W-1:0] lane;                    // Source lane
        frame_t            frame;
    } rx_word_t;

endpackage

`default_nettype wire

// File: src/i2s_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_rx_top (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire  [i2s_rx_pkg::NUM_LANES-1:0]                 sck,
    input  wire  [i2s_rx_pkg::NUM_LANES-1:0]                 ws,
    input  wire  [i2s_rx_pkg::NUM_LANES-1:0]                 sd,
    input  i2s_rx_pkg::i2s_cfg_t [i2s_rx_pkg::NUM_LANES-1:0] cfg,
    input  wire  [i2s_rx_pkg::NUM_LANES-1:0]                 overrun_clr,
    output i2s_rx_pkg::rx_word_t                             out_word,
    output logic                                             out_valid,
    input  wire                                              out_ready,
    output logic [i2s_rx_pkg::NUM_LANES-1:0]                 overrun
);

    i2s_rx_pkg::frame_t [i2s_rx_pkg::NUM_LANES-1:0] lane_frame;
    logic [i2s_rx_pkg::NUM_LANES-1:0]               lane_valid;
    logic [i2s_rx_pkg::NUM_LANES-1:0]               lane_ready;

    for (genvar g = 0; g < i2s_rx_pkg::NUM_LANES; g++)
    begin : g_lane
        i2s_rx_lane u_lane (
            .clk         (clk),
            .rst_n       (rst_n),
            .sck_pin     (sck[g]),
            .ws_pin      (ws[g]),
            .sd_pin      (sd[g]),
            .cfg         (cfg[g]),
            .overrun_clr (overrun_clr[g]),
            .out_frame   (lane_frame[g]),
            .out_valid   (lane_valid[g]),
            .out_ready   (lane_ready[g]),
            .overrun     (overrun[g])
        );
    end

    i2s_rx_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_frame  (lane_frame),
        .in_valid  (lane_valid),
        .in_ready  (lane_ready),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: src/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo (
    input  wire                 clk,
    input  wire                 rst_n,
    input  i2s_rx_pkg::frame_t  in_frame,
    input  wire                 in_valid,
    output logic                in_ready,
    output i2s_rx_pkg::frame_t  out_frame,
    output logic                out_valid,
    input  wire                 out_ready
);

    i2s_rx_pkg::frame_t mem [i2s_rx_pkg::FIFO_DEPTH];

    logic [i2s_rx_pkg::FIFO_AW-1:0] wr_ptr;
    logic [i2s_rx_pkg::FIFO_AW-1:0] rd_ptr;
    logic [i2s_rx_pkg::FIFO_AW:0]   count;          // One bit wider than pointers
    logic                           push;
    logic                           pop;

    assign in_ready  = (count != (i2s_rx_pkg::FIFO_AW+1)'(i2s_rx_pkg::FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_frame = mem[rd_ptr];

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    ////////////////////////////////////////
    // Pointers and fill level
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;            // Depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_frame;
    end

endmodule

`default_nettype wire

// File: testbench/i2s_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_rx_tb;

    logic                                           clk;
    logic                                           rst_n;
    logic [i2s_rx_pkg::NUM_LANES-1:0]               sck;
    logic [i2s_rx_pkg::NUM_LANES-1:0]               ws;
    logic [i2s_rx_pkg::NUM_LANES-1:0]               sd;
    i2s_rx_pkg::i2s_cfg_t [i2s_rx_pkg::NUM_LANES-1:0] cfg;
    logic [i2s_rx_pkg::NUM_LANES-1:0]               overrun_clr;
    i2s_rx_pkg::rx_word_t                           out_word;
    logic                                           out_valid;
    logic                                           out_ready;
    logic [i2s_rx_pkg::NUM_LANES-1:0]               overrun;

    logic [31:0]          exp_q [i2s_rx_pkg::NUM_LANES][$];  // Expected frames per lane
    int                   bist_idx [i2s_rx_pkg::NUM_LANES];
    int                   delivered [i2s_rx_pkg::NUM_LANES];
    int                   errors;
    int                   checks;
    bit                   subseq_mode;              // Drops allowed in overrun test
    bit                   rand_ready;
    bit                   ready_level;
    bit                   hold_pending;
    i2s_rx_pkg::rx_word_t hold_word;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    i2s_rx_top i2s_rx_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .sck         (sck),
        .ws          (ws),
        .sd          (sd),
        .cfg         (cfg),
        .overrun_clr (overrun_clr),
        .out_word    (out_word),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .overrun     (overrun)
    );

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [31:0] reference_frame(i2s_rx_pkg::i2s_cfg_t c,
                                                    logic [31:0] sent, int idx);
        longint unsigned next;
        logic [31:0]     value;
        if (!c.bist_sel)
            return sent;                            // Audio is the sent left/right pair
        value = c.bist_start;
        for (int k = 0; k < idx; k++)
        begin
            next = value;
            next = next + c.bist_inc;
            if (next > c.bist_limit)
                value = c.bist_start;               // Past the limit
            else
                value = next[31:0];
        end
        return value;
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // 32 bit slots per frame, 8 clk per slot, pins change on sck fall
    task automatic send_frames(input int lane, input int count);
        logic [31:0] data;
        for (int f = 0; f < count; f++)
        begin
            data = $urandom;
            if (cfg[lane].enable)
            begin
                exp_q[lane].push_back(reference_frame(cfg[lane], data, bist_idx[lane]));
                bist_idx[lane]++;
            end
            for (int j = 0; j < 32; j++)
            begin
                @(posedge clk);
                #1;
                sck[lane] = 1'b0;
                sd[lane]  = data[31-j];             // Left in upper half, MSB first
                ws[lane]  = (j >= 15 && j <= 30);   // ws leads the MSB by one bit
                repeat (4) @(posedge clk);
                #1;
                sck[lane] = 1'b1;
                repeat (3) @(posedge clk);
            end
        end
    endtask

    task automatic set_lane(input int lane, input bit en, input bit bist,
                            input logic [31:0] start, input logic [31:0] limit,
                            input logic [7:0] inc);
        cfg[lane].bist_start = start;
        cfg[lane].bist_limit = limit;
        cfg[lane].bist_inc   = inc;
        @(posedge clk);                             // Start value preloads while idle
        #1;
        cfg[lane].enable     = en;
        cfg[lane].bist_sel   = bist;
        bist_idx[lane]       = 0;
    endtask

    task automatic drive_ready();
        bit use_rand;
        bit level;
        use_rand = rand_ready;                      // Sampled at the edge
        level    = ready_level;
        #1;
        out_ready = use_rand ? ($urandom_range(3) != 0) : level;
    endtask

    always @(posedge clk)
        drive_ready();

    ////////////////////////////////////////
    // Output compare
    ////////////////////////////////////////

    task automatic check_output();
        int          lane;
        logic [31:0] exp;
        bit          found;
        if (hold_pending)
        begin
            checks++;
            if (!out_valid)
            begin
                errors++;
                $display("out_valid dropped before the word was taken");
            end
            else if (out_word !== hold_word)
            begin
                errors++;
                $display("FAILED out_word: held %h, changed to %h", hold_word, out_word);
            end
        end
        if (out_valid && out_ready)
        begin
            lane = int'(out_word.lane);
            delivered[lane]++;
            checks++;
            if (subseq_mode)
            begin
                found = 1'b0;
                while (!found && exp_q[lane].size() > 0)
                begin
                    exp = exp_q[lane].pop_front();  // Skip dropped frames
                    if (exp === out_word.frame)
                        found = 1'b1;
                end
                if (!found)
                begin
                    errors++;
                    $display("FAILED out_word.frame lane %0d: %h is out of sent order",
                             lane, out_word.frame);
                end
            end
            else if (exp_q[lane].size() == 0)
            begin
                errors++;
                $display("Lane %0d delivered a frame that was never sent", lane);
            end
            else
            begin
                exp = exp_q[lane].pop_front();
                if (out_word.frame !== exp)
                begin
                    errors++;
                    $display("FAILED out_word.frame lane %0d: expected %h, got %h",
                             lane, exp, out_word.frame);
                end
            end
        end
        hold_pending = out_valid && !out_ready;
        hold_word    = out_word;
    endtask

    always @(posedge clk)
    begin
        if (rst_n)
            check_output();
    end

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, exp, got);
        end
    endtask

    ////////////////////////////////////////
    // Waits
    ////////////////////////////////////////

    task automatic wait_reset();
        int n;
        n = 0;
        while (!rst_n && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (!rst_n)
        begin
            errors++;
            $display("Timeout while waiting for reset release");
        end
    endtask

    task automatic wait_drained(input string phase);
        int n;
        n = 0;
        while ((exp_q[0].size() != 0 || exp_q[1].size() != 0 || out_valid) && n < 5000)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= 5000)
        begin
            errors++;
            $display("Timeout in %s, expected frames never arrived", phase);
        end
    endtask

    task automatic wait_idle();
        int n;
        int idle;
        n    = 0;
        idle = 0;
        while (idle < 64 && n < 5000)
        begin
            @(negedge clk);
            idle = out_valid ? 0 : idle + 1;
            n++;
        end
        if (idle < 64)
        begin
            errors++;
            $display("Timeout while waiting for the output to go idle");
        end
    endtask

    task automatic wait_overrun(input int lane);
        int n;
        n = 0;
        while (!overrun[lane] && n < 3000)
        begin
            @(negedge clk);
            n++;
        end
        if (!overrun[lane])
        begin
            errors++;
            $display("Timeout while waiting for overrun on lane %0d", lane);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        void'($urandom(32'h716e));
        sck          = '0;
        ws           = '0;
        sd           = '0;
        cfg          = '0;
        overrun_clr  = '0;
        out_ready    = 1'b0;
        ready_level  = 1'b0;
        rand_ready   = 1'b0;
        subseq_mode  = 1'b0;
        hold_pending = 1'b0;
        errors       = 0;
        checks       = 0;
        for (int i = 0; i < i2s_rx_pkg::NUM_LANES; i++)
        begin
            bist_idx[i]  = 0;
            delivered[i] = 0;
        end
        wait_reset();

        // Both lanes in audio mode
        @(posedge clk);
        #1;
        set_lane(0, 1'b1, 1'b0, '0, '0, '0);
        set_lane(1, 1'b1, 1'b0, '0, '0, '0);
        ready_level = 1'b1;
        fork
            send_frames(0, 6);
            send_frames(1, 6);
        join
        wait_drained("audio test");
        check_flag("overrun", |overrun, 1'b0);

        // Lane 1 switched off
        @(posedge clk);
        #1;
        set_lane(1, 1'b0, 1'b0, '0, '0, '0);
        fork
            send_frames(0, 4);
            send_frames(1, 4);
        join
        wait_drained("disabled lane test");

        // Self-test counters, lane 1 wraps through the carry
        @(posedge clk);
        #1;
        set_lane(0, 1'b1, 1'b1, 32'h0000_0100, 32'h0000_0150, 8'h10);
        set_lane(1, 1'b1, 1'b1, 32'hffff_fff0, 32'hffff_ffff, 8'h08);
        fork
            send_frames(0, 8);
            send_frames(1, 8);
        join
        wait_drained("self-test");

        // Random back-pressure
        @(posedge clk);
        #1;
        set_lane(0, 1'b1, 1'b0, '0, '0, '0);
        set_lane(1, 1'b1, 1'b0, '0, '0, '0);
        rand_ready = 1'b1;
        fork
            send_frames(0, 6);
            send_frames(1, 6);
        join
        wait_drained("back-pressure test");
        rand_ready = 1'b0;
        check_flag("overrun", |overrun, 1'b0);

        // Overflow lane 0 while the output is stalled
        @(posedge clk);
        #1;
        set_lane(1, 1'b0, 1'b0, '0, '0, '0);
        ready_level  = 1'b0;
        subseq_mode  = 1'b1;
        delivered[0] = 0;
        send_frames(0, i2s_rx_pkg::FIFO_DEPTH + 4);
        wait_overrun(0);
        check_flag("overrun[1]", overrun[1], 1'b0);
        @(posedge clk);
        #1;
        ready_level = 1'b1;
        wait_idle();
        checks++;
        if (delivered[0] < i2s_rx_pkg::FIFO_DEPTH)
        begin
            errors++;
            $display("Only %0d frames survived the overflow on lane 0", delivered[0]);
        end
        exp_q[0].delete();
        subseq_mode = 1'b0;
        @(posedge clk);
        #1;
        overrun_clr[0] = 1'b1;
        @(posedge clk);
        #1;
        overrun_clr[0] = 1'b0;
        check_flag("overrun[0]", overrun[0], 1'b0);
        send_frames(0, 4);
        wait_drained("overrun recovery");
        check_flag("overrun[0]", overrun[0], 1'b0);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);                  // Two cycles in reset
        #1;
        rst_n = 1'b1;
    end

    always #50 clk = ~clk;                          // 100 ns period

endmodule

`default_nettype wire
